//--- verification/decode_stim.txt
// First value is the vector count. Columns: instr pc valid stall prd_taken exp_op exp_type exp_imm
// exp_flags, bit 0 use_rs1 up to bit 13 ebreak, in the order of the output port list
2D
123450B7 00001000 1 0 0 01 0 12345000 808
FFFFF097 00001004 1 0 0 02 0 FFFFF000 80C
FF9FF0EF 00001008 1 0 1 03 0 FFFFFFF8 83C
004100E7 0000100C 1 0 1 04 0 00000004 839
00310863 00001010 1 0 1 05 5 00000010 03F
00311863 00001014 1 0 0 06 5 00000010 01F
00314863 00001018 1 0 0 07 5 00000010 01F
00315863 0000101C 1 0 0 08 5 00000010 01F
00316863 00001020 1 0 0 09 5 00000010 01F
FE317EE3 00001024 1 0 0 0A 5 FFFFFFFC 01F
FFF10083 00001028 1 0 0 0B 3 FFFFFFFF D49
00211083 0000102C 1 0 0 0C 3 00000002 E49
00812083 00001030 1 0 0 0D 3 00000008 849
00014083 00001034 1 0 0 0E 3 00000000 949
7FF15083 00001038 1 0 0 0F 3 000007FF A49
FE310F23 0000103C 1 0 0 10 4 FFFFFFFE 18B
00311223 00001040 1 0 0 11 4 00000004 28B
02312223 00001044 1 0 0 12 4 00000024 08B
FFB10093 00001048 1 0 0 13 2 FFFFFFFB 809
00112093 0000104C 1 0 0 14 2 00000001 809
80013093 00001050 1 0 0 15 2 FFFFF800 809
0FF14093 00001054 1 0 0 16 2 000000FF 809
01016093 00001058 1 0 0 17 2 00000010 809
0F017093 0000105C 1 0 0 18 2 000000F0 809
00511093 00001060 1 0 0 19 2 00000005 809
01F15093 00001064 1 0 0 1A 2 0000001F 809
40315093 00001068 1 0 0 1B 2 00000003 809
003100B3 0000106C 1 0 0 1C 1 00000000 803
403100B3 00001070 1 0 0 1D 1 00000000 803
003120B3 00001074 1 0 0 1E 1 00000000 803
003130B3 00001078 1 0 0 1F 1 00000000 803
003140B3 0000107C 1 0 0 20 1 00000000 803
003160B3 00001080 1 0 0 21 1 00000000 803
003170B3 00001084 1 0 0 22 1 00000000 803
003110B3 00001088 1 0 0 23 1 00000000 803
003150B3 0000108C 1 0 0 24 1 00000000 803
403150B3 00001090 1 0 0 25 1 00000000 803
00000073 00001094 1 0 0 26 6 00000000 1000
00100073 00001098 1 0 0 27 6 00000000 2000
FFFFFFFF 0000109C 1 0 0 00 0 00000000 0
023100B3 000010A0 1 0 0 00 0 00000000 0
003100B3 000010A4 1 1 0 1C 1 00000000 803
003100B3 000010A8 0 0 0 1C 1 00000000 803
FF9FF0EF 000010AC 1 1 1 03 0 FFFFFFF8 83C
00510093 000010B0 1 0 0 13 2 00000005 809

//--- rv32i_decode.f
verilog/rv32i_decode_pkg.sv
verilog/dcd_class_if.sv
verilog/imm_cand_if.sv
verilog/instr_classifier.sv
verilog/imm_extractor.sv
verilog/decode_register.sv
verilog/rv32i_decode.sv
verification/decode_props.sv
verification/decode_checker.sv
verification/tb_rv32i_decode.sv

//--- Makefile
# Verilator build and run for the rv32i_decode testbench

VERILATOR ?= verilator
TOP       ?= tb_rv32i_decode
FILELIST  ?= rv32i_decode.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+100

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv) $(wildcard verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || { echo "Decode simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_rv32i_decode.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv32i_decode;
    import rv32i_decode_pkg::*;

    localparam int COLS        = 9;     // Words per stim line
    localparam int MAX_VECS    = 64;
    localparam int SEED        = 80014;
    localparam int DRAIN_LIMIT = 16;    // Cycles allowed for the last slots

    logic        clk;
    logic        rst;
    logic        valid;
    logic        stall;
    logic        prd_taken;
    word_t       pc;
    word_t       instr;
    logic        out_valid;
    instr_e      out_op;
    instr_type_e out_type;
    reg_addr_t   out_rs1;
    reg_addr_t   out_rs2;
    reg_addr_t   out_rd;
    word_t       out_imm;
    word_t       out_pc;
    logic [13:0] out_flags;
    logic        exp_valid;
    instr_e      exp_op;
    instr_type_e exp_type;
    word_t       exp_imm;
    logic [13:0] exp_flags;
    logic [31:0] stim_mem [0:COLS*MAX_VECS];    // Word 0 is the vector count
    int          n_vecs;
    int          sent;
    int          timeouts;
    int          stim_errors;
    int          mismatches;
    int          checked;

    always #5 clk = ~clk;

    rv32i_decode dut_i (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_valid        (valid),
        .i_stall        (stall),
        .i_prd_taken    (prd_taken),
        .i_pc           (pc),
        .i_instr        (instr),
        .o_valid        (out_valid),
        .o_instr_op     (out_op),
        .o_instr_type   (out_type),
        .o_rs1_addr     (out_rs1),
        .o_rs2_addr     (out_rs2),
        .o_rd_addr      (out_rd),
        .o_imm          (out_imm),
        .o_pc           (out_pc),
        .o_use_rs1      (out_flags[0]),
        .o_use_rs2      (out_flags[1]),
        .o_op_a_use_pc  (out_flags[2]),
        .o_op_b_use_imm (out_flags[3]),
        .o_prd_en       (out_flags[4]),
        .o_predicted    (out_flags[5]),
        .o_load_en      (out_flags[6]),
        .o_store_en     (out_flags[7]),
        .o_lsu_byte     (out_flags[8]),
        .o_lsu_halfword (out_flags[9]),
        .o_lsu_signed   (out_flags[10]),
        .o_wren         (out_flags[11]),
        .o_ecall        (out_flags[12]),
        .o_ebreak       (out_flags[13])
    );

    decode_checker chk_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_exp_valid  (exp_valid),
        .i_exp_op     (exp_op),
        .i_exp_type   (exp_type),
        .i_exp_imm    (exp_imm),
        .i_exp_flags  (exp_flags),
        .i_exp_pc     (pc),
        .i_exp_instr  (instr),
        .i_dut_valid  (out_valid),
        .i_dut_op     (out_op),
        .i_dut_type   (out_type),
        .i_dut_imm    (out_imm),
        .i_dut_pc     (out_pc),
        .i_dut_rs1    (out_rs1),
        .i_dut_rs2    (out_rs2),
        .i_dut_rd     (out_rd),
        .i_dut_flags  (out_flags),
        .o_mismatches (mismatches),
        .o_checked    (checked)
    );

    task automatic drive_vector(input int idx);
        int base;
        base = 1 + idx * COLS;
        instr     <= stim_mem[base];
        pc        <= stim_mem[base+1];
        valid     <= stim_mem[base+2][0];
        stall     <= stim_mem[base+3][0];
        prd_taken <= stim_mem[base+4][0];
        exp_valid <= stim_mem[base+2][0] & ~stim_mem[base+3][0];    // Accept condition
        exp_op    <= instr_e'(stim_mem[base+5][5:0]);
        exp_type  <= instr_type_e'(stim_mem[base+6][2:0]);
        exp_imm   <= stim_mem[base+7];
        exp_flags <= stim_mem[base+8][13:0];
        if (stim_mem[base+2][0] && !stim_mem[base+3][0]) sent++;
    endtask

    task automatic insert_bubble();
        valid     <= 1'b0;
        stall     <= 1'b0;
        prd_taken <= 1'b0;
        exp_valid <= 1'b0;
        exp_flags <= '0;
    endtask

    // Last accepted slots still travel through the output register
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (checked != sent && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (checked != sent) begin
            $display("Timeout: only %0d of %0d accepted slots reached the outputs",
                     checked, sent);
            timeouts++;
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        valid       = 1'b0;
        stall       = 1'b0;
        prd_taken   = 1'b0;
        pc          = '0;
        instr       = '0;
        exp_valid   = 1'b0;
        exp_op      = OP_NONE;
        exp_type    = TYPE_NONE;
        exp_imm     = '0;
        exp_flags   = '0;
        sent        = 0;
        timeouts    = 0;
        stim_errors = 0;
        void'($urandom(SEED));
        $readmemh("verification/decode_stim.txt", stim_mem);
        n_vecs = int'(stim_mem[0]);
        if (n_vecs < 1 || n_vecs > MAX_VECS) begin
            $display("Stim file gives an unusable vector count of %0d", n_vecs);
            stim_errors++;
            n_vecs = 0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int v = 0; v < n_vecs; v++) begin
            @(posedge clk);
            drive_vector(v);
            if ($urandom % 4 == 0) begin    // Occasional bubble between lines
                @(posedge clk);
                insert_bubble();
            end
        end
        @(posedge clk);
        insert_bubble();
        wait_drain();
        $display("Decode run: %0d slots, %0d mismatches, %0d timeouts, %0d assertion, %0d stim",
                 sent, mismatches, timeouts, dut_i.props_i.fail_count, stim_errors);
        if (mismatches == 0 && timeouts == 0 && stim_errors == 0
            && dut_i.props_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_rv32i_decode

`default_nettype wire

//--- verification/decode_checker.sv
`timescale 1ns/1ns
`default_nettype none

module decode_checker (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_exp_valid,
    input  rv32i_decode_pkg::instr_e      i_exp_op,
    input  rv32i_decode_pkg::instr_type_e i_exp_type,
    input  rv32i_decode_pkg::word_t       i_exp_imm,
    input  logic [13:0]                   i_exp_flags,
    input  rv32i_decode_pkg::word_t       i_exp_pc,
    input  rv32i_decode_pkg::word_t       i_exp_instr,
    input  logic                          i_dut_valid,
    input  rv32i_decode_pkg::instr_e      i_dut_op,
    input  rv32i_decode_pkg::instr_type_e i_dut_type,
    input  rv32i_decode_pkg::word_t       i_dut_imm,
    input  rv32i_decode_pkg::word_t       i_dut_pc,
    input  rv32i_decode_pkg::reg_addr_t   i_dut_rs1,
    input  rv32i_decode_pkg::reg_addr_t   i_dut_rs2,
    input  rv32i_decode_pkg::reg_addr_t   i_dut_rd,
    input  logic [13:0]                   i_dut_flags,
    output int                            o_mismatches,
    output int                            o_checked
);
    import rv32i_decode_pkg::*;

    logic        d_valid = 1'b0;
    instr_e      d_op;
    instr_type_e d_type;
    word_t       d_imm;
    word_t       d_pc;
    word_t       d_instr;
    logic [13:0] d_flags;
    logic        seen_accept = 1'b0;
    int          mismatches = 0;
    int          checked = 0;

    assign o_mismatches = mismatches;
    assign o_checked    = checked;

    function automatic string flag_name(input int idx);
        case (idx)
            0:       return "o_use_rs1";
            1:       return "o_use_rs2";
            2:       return "o_op_a_use_pc";
            3:       return "o_op_b_use_imm";
            4:       return "o_prd_en";
            5:       return "o_predicted";
            6:       return "o_load_en";
            7:       return "o_store_en";
            8:       return "o_lsu_byte";
            9:       return "o_lsu_halfword";
            10:      return "o_lsu_signed";
            11:      return "o_wren";
            12:      return "o_ecall";
            default: return "o_ebreak";
        endcase
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            mismatches++;
        end
    endtask

    // One cycle of latency through the decode register
    always @(posedge i_clk) begin
        d_valid <= i_exp_valid;
        d_op    <= i_exp_op;
        d_type  <= i_exp_type;
        d_imm   <= i_exp_imm;
        d_pc    <= i_exp_pc;
        d_instr <= i_exp_instr;
        d_flags <= i_exp_flags;
    end

    // Outputs settle after the rising edge
    always @(negedge i_clk) begin
        logic [13:0] want_flags;
        if (!i_rst) begin
            want_flags = d_valid ? d_flags : 14'd0;    // Bubbles carry no flags
            compare_word("o_valid", 32'(d_valid), 32'(i_dut_valid));
            if (d_valid) begin
                checked++;
                seen_accept = 1'b1;
                compare_word("o_instr_op", 32'(d_op), 32'(i_dut_op));
                compare_word("o_instr_type", 32'(d_type), 32'(i_dut_type));
                compare_word("o_imm", d_imm, i_dut_imm);
                compare_word("o_pc", d_pc, i_dut_pc);
                compare_word("o_rs1_addr", 32'(d_instr[19:15]), 32'(i_dut_rs1));
                compare_word("o_rs2_addr", 32'(d_instr[24:20]), 32'(i_dut_rs2));
                compare_word("o_rd_addr", 32'(d_instr[11:7]), 32'(i_dut_rd));
            end else if (!seen_accept) begin
                compare_word("o_instr_op", 32'(OP_NONE), 32'(i_dut_op));
                compare_word("o_instr_type", 32'(TYPE_NONE), 32'(i_dut_type));
            end
            for (int i = 0; i < 14; i++) begin
                compare_word(flag_name(i), 32'(want_flags[i]), 32'(i_dut_flags[i]));
            end
        end
    end

endmodule : decode_checker

`default_nettype wire

//--- verification/decode_props.sv
`timescale 1ns/1ns
`default_nettype none

module decode_props (
    input logic        i_clk,
    input logic        i_rst,
    input logic        i_out_valid,
    input logic [13:0] i_flags,
    input logic        i_load_en,
    input logic        i_store_en,
    input logic        i_ecall,
    input logic        i_ebreak
);

    int fail_count = 0;    // Read by the testbench at the end of the run

    flags_need_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_out_valid |-> (i_flags == '0))
        else begin
            $error("decode flag high while o_valid is low");
            fail_count++;
        end

    load_store_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_load_en && i_store_en))
        else begin
            $error("o_load_en and o_store_en high together");
            fail_count++;
        end

    // A system slot is either ECALL or EBREAK
    ecall_ebreak_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_ecall && i_ebreak))
        else begin
            $error("o_ecall and o_ebreak high together");
            fail_count++;
        end

endmodule : decode_props

bind rv32i_decode decode_props props_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_out_valid (o_valid),
    .i_flags     ({o_ebreak, o_ecall, o_wren, o_lsu_signed, o_lsu_halfword, o_lsu_byte,
                   o_store_en, o_load_en, o_predicted, o_prd_en, o_op_b_use_imm,
                   o_op_a_use_pc, o_use_rs2, o_use_rs1}),
    .i_load_en   (o_load_en),
    .i_store_en  (o_store_en),
    .i_ecall     (o_ecall),
    .i_ebreak    (o_ebreak)
);

`default_nettype wire

//--- verilog/rv32i_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rv32i_decode (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_valid,
    input  logic                           i_stall,
    input  logic                           i_prd_taken,    // Fetch predicted taken
    input  rv32i_decode_pkg::word_t        i_pc,
    input  rv32i_decode_pkg::word_t        i_instr,
    output logic                           o_valid,
    output rv32i_decode_pkg::instr_e       o_instr_op,
    output rv32i_decode_pkg::instr_type_e  o_instr_type,
    output rv32i_decode_pkg::reg_addr_t    o_rs1_addr,
    output rv32i_decode_pkg::reg_addr_t    o_rs2_addr,
    output rv32i_decode_pkg::reg_addr_t    o_rd_addr,
    output rv32i_decode_pkg::word_t        o_imm,
    output rv32i_decode_pkg::word_t        o_pc,
    output logic                           o_use_rs1,
    output logic                           o_use_rs2,
    output logic                           o_op_a_use_pc,
    output logic                           o_op_b_use_imm,
    output logic                           o_prd_en,
    output logic                           o_predicted,
    output logic                           o_load_en,
    output logic                           o_store_en,
    output logic                           o_lsu_byte,
    output logic                           o_lsu_halfword,
    output logic                           o_lsu_signed,
    output logic                           o_wren,
    output logic                           o_ecall,
    output logic                           o_ebreak
);

    dcd_class_if class_bus ();
    imm_cand_if  imm_bus ();

    // Classification and immediate building run in parallel
    instr_classifier u_classifier (
        .i_instr (i_instr),
        .o_class (class_bus.producer)
    );

    imm_extractor u_imm_extractor (
        .i_instr (i_instr),
        .o_imm   (imm_bus.producer)
    );

    decode_register u_decode_register (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_stall        (i_stall),
        .i_prd_taken    (i_prd_taken),
        .i_pc           (i_pc),
        .i_instr        (i_instr),
        .i_class        (class_bus.consumer),
        .i_imm          (imm_bus.consumer),
        .o_valid        (o_valid),
        .o_instr_op     (o_instr_op),
        .o_instr_type   (o_instr_type),
        .o_rs1_addr     (o_rs1_addr),
        .o_rs2_addr     (o_rs2_addr),
        .o_rd_addr      (o_rd_addr),
        .o_imm          (o_imm),
        .o_pc           (o_pc),
        .o_use_rs1      (o_use_rs1),
        .o_use_rs2      (o_use_rs2),
        .o_op_a_use_pc  (o_op_a_use_pc),
        .o_op_b_use_imm (o_op_b_use_imm),
        .o_prd_en       (o_prd_en),
        .o_predicted    (o_predicted),
        .o_load_en      (o_load_en),
        .o_store_en     (o_store_en),
        .o_lsu_byte     (o_lsu_byte),
        .o_lsu_halfword (o_lsu_halfword),
        .o_lsu_signed   (o_lsu_signed),
        .o_wren         (o_wren),
        .o_ecall        (o_ecall),
        .o_ebreak       (o_ebreak)
    );

endmodule : rv32i_decode

`default_nettype wire

//--- verilog/decode_register.sv
`timescale 1ns/1ns
`default_nettype none

module decode_register (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_valid,
    input  logic                           i_stall,
    input  logic                           i_prd_taken,
    input  rv32i_decode_pkg::word_t        i_pc,
    input  rv32i_decode_pkg::word_t        i_instr,
    dcd_class_if.consumer                  i_class,
    imm_cand_if.consumer                   i_imm,
    output logic                           o_valid,
    output rv32i_decode_pkg::instr_e       o_instr_op,
    output rv32i_decode_pkg::instr_type_e  o_instr_type,
    output rv32i_decode_pkg::reg_addr_t    o_rs1_addr,
    output rv32i_decode_pkg::reg_addr_t    o_rs2_addr,
    output rv32i_decode_pkg::reg_addr_t    o_rd_addr,
    output rv32i_decode_pkg::word_t        o_imm,
    output rv32i_decode_pkg::word_t        o_pc,
    output logic                           o_use_rs1,
    output logic                           o_use_rs2,
    output logic                           o_op_a_use_pc,
    output logic                           o_op_b_use_imm,
    output logic                           o_prd_en,
    output logic                           o_predicted,
    output logic                           o_load_en,
    output logic                           o_store_en,
    output logic                           o_lsu_byte,
    output logic                           o_lsu_halfword,
    output logic                           o_lsu_signed,
    output logic                           o_wren,
    output logic                           o_ecall,
    output logic                           o_ebreak
);
    import rv32i_decode_pkg::*;

    logic  accept;
    word_t imm_sel;

    assign accept = i_valid & ~i_stall;    // Stall turns the slot into a bubble

    always_comb begin
        case (i_class.imm_fmt)
            IMM_I:     imm_sel = i_imm.imm_i;
            IMM_S:     imm_sel = i_imm.imm_s;
            IMM_B:     imm_sel = i_imm.imm_b;
            IMM_SHAMT: imm_sel = i_imm.imm_shamt;
            IMM_J:     imm_sel = i_imm.imm_j;
            IMM_U:     imm_sel = i_imm.imm_u;
            default:   imm_sel = '0;      // R type and unknown
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid        <= 1'b0;
            o_instr_op     <= OP_NONE;
            o_instr_type   <= TYPE_NONE;
            o_use_rs1      <= 1'b0;
            o_use_rs2      <= 1'b0;
            o_op_a_use_pc  <= 1'b0;
            o_op_b_use_imm <= 1'b0;
            o_prd_en       <= 1'b0;
            o_predicted    <= 1'b0;
            o_load_en      <= 1'b0;
            o_store_en     <= 1'b0;
            o_lsu_byte     <= 1'b0;
            o_lsu_halfword <= 1'b0;
            o_lsu_signed   <= 1'b0;
            o_wren         <= 1'b0;
            o_ecall        <= 1'b0;
            o_ebreak       <= 1'b0;
        end else begin
            o_valid        <= accept;
            o_instr_op     <= i_class.instr_op;
            o_instr_type   <= i_class.instr_type;
            o_use_rs1      <= accept & i_class.use_rs1;
            o_use_rs2      <= accept & i_class.use_rs2;
            o_op_a_use_pc  <= accept & i_class.op_a_use_pc;
            o_op_b_use_imm <= accept & i_class.op_b_use_imm;
            o_prd_en       <= accept & i_class.prd_en;
            o_predicted    <= accept & i_prd_taken;
            o_load_en      <= accept & i_class.load_en;
            o_store_en     <= accept & i_class.store_en;
            o_lsu_byte     <= accept & i_class.lsu_byte;
            o_lsu_halfword <= accept & i_class.lsu_halfword;
            o_lsu_signed   <= accept & i_class.lsu_signed;
            o_wren         <= accept & i_class.wren;
            o_ecall        <= accept & i_class.ecall;
            o_ebreak       <= accept & i_class.ebreak;
        end
    end

    // Payload is meaningful only with o_valid
    always_ff @(posedge i_clk) begin
        o_rs1_addr <= i_instr[19:15];
        o_rs2_addr <= i_instr[24:20];
        o_rd_addr  <= i_instr[11:7];
        o_imm      <= imm_sel;
        o_pc       <= i_pc;
    end

endmodule : decode_register

`default_nettype wire

//--- verilog/imm_extractor.sv
`timescale 1ns/1ns
`default_nettype none

module imm_extractor (
    input  rv32i_decode_pkg::word_t i_instr,
    imm_cand_if.producer            o_imm
);
    import rv32i_decode_pkg::*;

    logic sign;

    assign sign = i_instr[31];

    // Loads, ALU immediates and JALR
    assign o_imm.imm_i = {{20{sign}}, i_instr[31:20]};

    assign o_imm.imm_s = {{20{sign}}, i_instr[31:25], i_instr[11:7]};

    // Branch offset is always even
    assign o_imm.imm_b = {{19{sign}}, sign, i_instr[7], i_instr[30:25],
                          i_instr[11:8], 1'b0};

    assign o_imm.imm_shamt = {{(XLEN-5){1'b0}}, i_instr[24:20]};

    assign o_imm.imm_j = {{11{sign}}, sign, i_instr[19:12], i_instr[20],
                          i_instr[30:21], 1'b0};

    // LUI and AUIPC
    assign o_imm.imm_u = {i_instr[31:12], 12'h000};

endmodule : imm_extractor

`default_nettype wire

//--- verilog/instr_classifier.sv
`timescale 1ns/1ns
`default_nettype none

module instr_classifier (
    input  rv32i_decode_pkg::word_t i_instr,
    dcd_class_if.producer           o_class
);
    import rv32i_decode_pkg::*;

    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    instr_e      instr_op;
    instr_type_e instr_type;
    imm_fmt_e    imm_fmt;
    logic        known;
    logic        is_lui, is_auipc, is_jal, is_jalr;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    // Class and format follow the opcode and are cleared again if no operation matched
    always_comb begin
        instr_op   = OP_NONE;
        instr_type = TYPE_NONE;
        imm_fmt    = IMM_ZERO;
        case (opcode)
            OPC_LUI: begin
                instr_op = OP_LUI;
                imm_fmt  = IMM_U;
            end
            OPC_AUIPC: begin
                instr_op = OP_AUIPC;
                imm_fmt  = IMM_U;
            end
            OPC_JAL: begin
                instr_op = OP_JAL;
                imm_fmt  = IMM_J;
            end
            OPC_JALR: begin
                instr_op = OP_JALR;
                imm_fmt  = IMM_I;
            end
            OPC_BRANCH: begin
                instr_type = TYPE_B;
                imm_fmt    = IMM_B;
                case (funct3)
                    3'b000:  instr_op = OP_BEQ;
                    3'b001:  instr_op = OP_BNE;
                    3'b100:  instr_op = OP_BLT;
                    3'b101:  instr_op = OP_BGE;
                    3'b110:  instr_op = OP_BLTU;
                    3'b111:  instr_op = OP_BGEU;
                    default: instr_op = OP_NONE;
                endcase
            end
            OPC_LOAD: begin
                instr_type = TYPE_L;
                imm_fmt    = IMM_I;
                case (funct3)
                    3'b000:  instr_op = OP_LB;
                    3'b001:  instr_op = OP_LH;
                    3'b010:  instr_op = OP_LW;
                    3'b100:  instr_op = OP_LBU;
                    3'b101:  instr_op = OP_LHU;
                    default: instr_op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                instr_type = TYPE_S;
                imm_fmt    = IMM_S;
                case (funct3)
                    3'b000:  instr_op = OP_SB;
                    3'b001:  instr_op = OP_SH;
                    3'b010:  instr_op = OP_SW;
                    default: instr_op = OP_NONE;
                endcase
            end
            OPC_OP_IMM: begin
                instr_type = TYPE_I;
                imm_fmt    = IMM_I;
                case (funct3)
                    3'b000: instr_op = OP_ADDI;
                    3'b010: instr_op = OP_SLTI;
                    3'b011: instr_op = OP_SLTIU;
                    3'b100: instr_op = OP_XORI;
                    3'b110: instr_op = OP_ORI;
                    3'b111: instr_op = OP_ANDI;
                    3'b001: begin
                        imm_fmt = IMM_SHAMT;
                        if (funct7 == F7_BASE) instr_op = OP_SLLI;
                    end
                    default: begin                   // Right shifts with funct3 101
                        imm_fmt = IMM_SHAMT;
                        if (funct7 == F7_BASE)     instr_op = OP_SRLI;
                        else if (funct7 == F7_ALT) instr_op = OP_SRAI;
                    end
                endcase
            end
            OPC_OP: begin
                instr_type = TYPE_R;
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        3'b000: instr_op = OP_ADD;
                        3'b001: instr_op = OP_SLL;
                        3'b010: instr_op = OP_SLT;
                        3'b011: instr_op = OP_SLTU;
                        3'b100: instr_op = OP_XOR;
                        3'b101: instr_op = OP_SRL;
                        3'b110: instr_op = OP_OR;
                        default: instr_op = OP_AND;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    if (funct3 == 3'b000)      instr_op = OP_SUB;
                    else if (funct3 == 3'b101) instr_op = OP_SRA;
                end
            end
            OPC_SYSTEM: begin
                instr_type = TYPE_E;
                if (funct7 == F7_BASE && i_instr[19:7] == 13'd0) begin
                    if (i_instr[24:20] == 5'd0)      instr_op = OP_ECALL;
                    else if (i_instr[24:20] == 5'd1) instr_op = OP_EBREAK;
                end
            end
            default: ;
        endcase
        if (instr_op == OP_NONE) begin               // Unknown encoding
            instr_type = TYPE_NONE;
            imm_fmt    = IMM_ZERO;
        end
    end

    assign known    = (instr_op != OP_NONE);
    assign is_lui   = (instr_op == OP_LUI);
    assign is_auipc = (instr_op == OP_AUIPC);
    assign is_jal   = (instr_op == OP_JAL);
    assign is_jalr  = (instr_op == OP_JALR);

    assign o_class.instr_op     = instr_op;
    assign o_class.instr_type   = instr_type;
    assign o_class.imm_fmt      = imm_fmt;
    assign o_class.use_rs1      = known & ~(is_lui | is_auipc | is_jal | (instr_type == TYPE_E));
    assign o_class.use_rs2      = (instr_type == TYPE_B) | (instr_type == TYPE_S)
                                | (instr_type == TYPE_R);
    assign o_class.op_a_use_pc  = is_auipc | is_jal | (instr_type == TYPE_B);
    assign o_class.op_b_use_imm = is_auipc | is_jal | is_jalr | is_lui
                                | (instr_type inside {TYPE_L, TYPE_I, TYPE_S, TYPE_B});
    assign o_class.prd_en       = (instr_type == TYPE_B) | is_jal | is_jalr;
    assign o_class.wren         = is_auipc | is_jal | is_jalr | is_lui
                                | (instr_type inside {TYPE_L, TYPE_I, TYPE_R});
    assign o_class.load_en      = (instr_type == TYPE_L);
    assign o_class.store_en     = (instr_type == TYPE_S);
    assign o_class.lsu_byte     = instr_op inside {OP_LB, OP_LBU, OP_SB};
    assign o_class.lsu_halfword = instr_op inside {OP_LH, OP_LHU, OP_SH};
    assign o_class.lsu_signed   = instr_op inside {OP_LB, OP_LH};    // LW needs no extension
    assign o_class.ecall        = (instr_op == OP_ECALL);
    assign o_class.ebreak       = (instr_op == OP_EBREAK);

endmodule : instr_classifier

`default_nettype wire

//--- verilog/imm_cand_if.sv
`timescale 1ns/1ns
`default_nettype none

interface imm_cand_if;
    import rv32i_decode_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_shamt;    // Zero extended
    word_t imm_j;
    word_t imm_u;

    modport producer (output imm_i, imm_s, imm_b, imm_shamt, imm_j, imm_u);
    modport consumer (input  imm_i, imm_s, imm_b, imm_shamt, imm_j, imm_u);

endinterface : imm_cand_if

`default_nettype wire

//--- verilog/dcd_class_if.sv
`timescale 1ns/1ns
`default_nettype none

interface dcd_class_if;
    import rv32i_decode_pkg::*;

    instr_e      instr_op;
    instr_type_e instr_type;
    imm_fmt_e    imm_fmt;
    logic        use_rs1, use_rs2;
    logic        op_a_use_pc, op_b_use_imm;
    logic        prd_en;                          // Branch predictor update
    logic        load_en, store_en;
    logic        lsu_byte, lsu_halfword, lsu_signed;
    logic        wren;
    logic        ecall, ebreak;

    modport producer (
        output instr_op, instr_type, imm_fmt, use_rs1, use_rs2, op_a_use_pc, op_b_use_imm,
               prd_en, load_en, store_en, lsu_byte, lsu_halfword, lsu_signed, wren,
               ecall, ebreak
    );
    modport consumer (
        input  instr_op, instr_type, imm_fmt, use_rs1, use_rs2, op_a_use_pc, op_b_use_imm,
               prd_en, load_en, store_en, lsu_byte, lsu_halfword, lsu_signed, wren,
               ecall, ebreak
    );

endinterface : dcd_class_if

`default_nettype wire

//--- verilog/rv32i_decode_pkg.sv
`default_nettype none

package rv32i_decode_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;

    localparam opcode_t OPC_LOAD   = 7'b000_0011;
    localparam opcode_t OPC_STORE  = 7'b010_0011;
    localparam opcode_t OPC_BRANCH = 7'b110_0011;
    localparam opcode_t OPC_OP     = 7'b011_0011;
    localparam opcode_t OPC_OP_IMM = 7'b001_0011;
    localparam opcode_t OPC_SYSTEM = 7'b111_0011;
    localparam opcode_t OPC_LUI    = 7'b011_0111;
    localparam opcode_t OPC_AUIPC  = 7'b001_0111;
    localparam opcode_t OPC_JAL    = 7'b110_1111;
    localparam opcode_t OPC_JALR   = 7'b110_0111;

    localparam logic [6:0] F7_BASE = 7'b000_0000;
    localparam logic [6:0] F7_ALT  = 7'b010_0000;    // SUB, SRA, SRAI

    // JAL, JALR, LUI and AUIPC have no class of their own
    typedef enum logic [2:0] {
        TYPE_NONE = 3'd0,
        TYPE_R    = 3'd1,
        TYPE_I    = 3'd2,
        TYPE_L    = 3'd3,
        TYPE_S    = 3'd4,
        TYPE_B    = 3'd5,
        TYPE_E    = 3'd6
    } instr_type_e;

    typedef enum logic [5:0] {
        OP_NONE,
        OP_LUI, OP_AUIPC,
        OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ECALL, OP_EBREAK
    } instr_e;

    typedef enum logic [2:0] {
        IMM_ZERO  = 3'd0,
        IMM_I     = 3'd1,
        IMM_S     = 3'd2,
        IMM_B     = 3'd3,
        IMM_SHAMT = 3'd4,
        IMM_J     = 3'd5,
        IMM_U     = 3'd6
    } imm_fmt_e;

endpackage : rv32i_decode_pkg

`default_nettype wire
